// File: Bender.yml
package:
  name: dfg_engine

sources:
  - include_dirs:
      - common
    files:
      - common/dfg_pkg.sv
      - datapath/arith_unit.sv
      - datapath/dfg_datapath.sv
      - design/result_queue.sv
      - design/dfg_top.sv
  - target: test
    include_dirs:
      - common
      - tests
    files:
      - tests/tb_dfg_top.sv

// File: common/dfg_cfg.svh
// word width, operator latency and result queue depth macros
`ifndef DFG_CFG_SVH
`define DFG_CFG_SVH

// width of one operand or result word
`define DFG_WORD_BITS 32

// cycles from operand capture to result in every arithmetic unit
`define DFG_OP_LATENCY 2

// result queue entries
`define DFG_QUEUE_DEPTH 4

`endif

// File: common/dfg_pkg.sv
// arithmetic word type, operand packet and result packet structs
`include "dfg_cfg.svh"

package dfg_pkg;

    // one arithmetic word, all math wraps mod 2^32
    typedef logic [`DFG_WORD_BITS-1:0] word_t;

    // five operands of one input packet, a sits in the top bits
    typedef struct packed {
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        word_t e;
    } operand_set_t;

    // four results of one output packet
    typedef struct packed {
        word_t r1;
        word_t r2;
        word_t r3;
        word_t r4;
    } result_set_t;

endpackage

// File: datapath/arith_unit.sv
// arith_unit, a pipelined modular adder or multiplier with a stall enable
`timescale 1ns/1ps
`include "dfg_cfg.svh"

module arith_unit
    import dfg_pkg::*;
#(
    // 0 selects add, 1 selects multiply
    parameter bit IS_MUL = 1'b0
)
(
    input  logic  clock,
    input  logic  rst,
    input  logic  advance,
    input  word_t op_a,
    input  word_t op_b,
    output word_t result
);

    localparam int HALF = `DFG_WORD_BITS / 2;
    localparam int TAIL = `DFG_OP_LATENCY - 1;

    typedef logic [HALF-1:0] half_t;

    // value leaving the first stage, before the output registers
    word_t final_val;
    word_t tail_q [TAIL];

    generate
        if (IS_MUL)
        begin : g_mul
            // partial products, only the low half of each cross term survives mod 2^32
            word_t pp_lo;
            half_t pp_hl;
            half_t pp_lh;

            always_ff @(posedge clock)
            begin
                if (rst)
                begin
                    pp_lo <= '0;
                    pp_hl <= '0;
                    pp_lh <= '0;
                end
                else if (advance)
                begin
                    pp_lo <= op_a[HALF-1:0] * op_b[HALF-1:0];
                    pp_hl <= op_a[`DFG_WORD_BITS-1:HALF] * op_b[HALF-1:0];
                    pp_lh <= op_a[HALF-1:0] * op_b[`DFG_WORD_BITS-1:HALF];
                end
            end

            assign final_val = pp_lo + {half_t'(pp_hl + pp_lh), {HALF{1'b0}}};
        end
        else
        begin : g_add
            word_t sum_q;

            always_ff @(posedge clock)
            begin
                if (rst)
                begin
                    sum_q <= '0;
                end
                else if (advance)
                begin
                    sum_q <= op_a + op_b;
                end
            end

            assign final_val = sum_q;
        end
    endgenerate

    // remaining latency, one register per extra cycle
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < TAIL; i++)
            begin
                tail_q[i] <= '0;
            end
        end
        else if (advance)
        begin
            tail_q[0] <= final_val;
            for (int i = 1; i < TAIL; i++)
            begin
                tail_q[i] <= tail_q[i-1];
            end
        end
    end

    assign result = tail_q[TAIL-1];

    // an X here means an upstream register was never loaded
    assert property (@(posedge clock) disable iff (rst) advance |-> !$isunknown(result))
        else $error("arith_unit result unknown while advancing");

endmodule

// File: datapath/dfg_datapath.sv
// dfg_datapath, operand register, four operator layers, delay lines and valid pipeline
`timescale 1ns/1ps
`include "dfg_cfg.svh"

module dfg_datapath
    import dfg_pkg::*;
(
    input  logic         clock,
    input  logic         rst,
    input  logic         in_valid,
    input  operand_set_t in_data,
    input  logic         advance,
    output logic         res_valid,
    output result_set_t  res_data
);

    localparam int LAT = `DFG_OP_LATENCY;
    // operand register plus four layers
    localparam int DEPTH = 1 + 4 * LAT;

    operand_set_t     opnd_q;
    logic [DEPTH-1:0] vld_q;

    word_t p;
    word_t q;
    word_t s1;
    word_t s2;
    word_t t;
    word_t u;
    word_t v;
    word_t w;
    word_t r1;
    word_t r2;
    word_t r3;
    word_t r4;

    // t and u wait here while layer 3 works on them
    word_t [LAT-1:0] t_dly;
    word_t [LAT-1:0] u_dly;

    // operands load only on an accepted packet, bubbles reuse stale data
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            opnd_q <= '0;
            vld_q  <= '0;
        end
        else if (advance)
        begin
            if (in_valid)
            begin
                opnd_q <= in_data;
            end
            vld_q <= {vld_q[DEPTH-2:0], in_valid};
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            t_dly <= '0;
            u_dly <= '0;
        end
        else if (advance)
        begin
            t_dly <= {t_dly[LAT-2:0], t};
            u_dly <= {u_dly[LAT-2:0], u};
        end
    end

    // layer 1
    arith_unit #(.IS_MUL(1'b0)) i_p_add (.clock, .rst, .advance,
        .op_a(opnd_q.a), .op_b(opnd_q.b), .result(p));
    arith_unit #(.IS_MUL(1'b1)) i_q_mul (.clock, .rst, .advance,
        .op_a(opnd_q.c), .op_b(opnd_q.d), .result(q));
    arith_unit #(.IS_MUL(1'b0)) i_s1_add (.clock, .rst, .advance,
        .op_a(opnd_q.c), .op_b(opnd_q.a), .result(s1));
    arith_unit #(.IS_MUL(1'b1)) i_s2_mul (.clock, .rst, .advance,
        .op_a(opnd_q.e), .op_b(opnd_q.d), .result(s2));

    // layer 2
    arith_unit #(.IS_MUL(1'b0)) i_t_add (.clock, .rst, .advance,
        .op_a(p), .op_b(q), .result(t));
    arith_unit #(.IS_MUL(1'b1)) i_u_mul (.clock, .rst, .advance,
        .op_a(s1), .op_b(s2), .result(u));

    // layer 3
    arith_unit #(.IS_MUL(1'b0)) i_v_add (.clock, .rst, .advance,
        .op_a(t), .op_b(u), .result(v));
    arith_unit #(.IS_MUL(1'b1)) i_w_mul (.clock, .rst, .advance,
        .op_a(t), .op_b(u), .result(w));

    // layer 4, delayed t and u line up with v and w
    arith_unit #(.IS_MUL(1'b1)) i_r1_mul (.clock, .rst, .advance,
        .op_a(v), .op_b(w), .result(r1));
    arith_unit #(.IS_MUL(1'b0)) i_r2_add (.clock, .rst, .advance,
        .op_a(v), .op_b(u_dly[LAT-1]), .result(r2));
    arith_unit #(.IS_MUL(1'b1)) i_r3_mul (.clock, .rst, .advance,
        .op_a(t_dly[LAT-1]), .op_b(w), .result(r3));
    arith_unit #(.IS_MUL(1'b0)) i_r4_add (.clock, .rst, .advance,
        .op_a(t_dly[LAT-1]), .op_b(u_dly[LAT-1]), .result(r4));

    assign res_valid = vld_q[DEPTH-1];
    assign res_data  = '{r1: r1, r2: r2, r3: r3, r4: r4};

    // a stall must freeze packet positions and the results held in the layers
    assert property (@(posedge clock) disable iff (rst)
        !advance |=> $stable(vld_q) && $stable(res_data))
        else $error("datapath moved during a stall");

endmodule

// File: design/dfg_top.sv
// dfg_top, datapath and result queue joined by the advance handshake
`timescale 1ns/1ps

module dfg_top
    import dfg_pkg::*;
(
    input  logic         clock,
    input  logic         rst,
    input  logic         in_valid,
    output logic         in_ready,
    input  operand_set_t in_data,
    output logic         out_valid,
    input  logic         out_ready,
    output result_set_t  out_data
);

    logic        res_valid;
    result_set_t res_data;

    // in_ready doubles as the advance wire, a packet enters only when the pipe shifts
    dfg_datapath i_datapath (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .advance   (in_ready),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    result_queue i_result_queue (
        .clock     (clock),
        .rst       (rst),
        .res_valid (res_valid),
        .res_data  (res_data),
        .advance   (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

// File: design/result_queue.sv
// result_queue, circular output FIFO that drives advance and the output handshake
`timescale 1ns/1ps
`include "dfg_cfg.svh"

module result_queue
    import dfg_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic        res_valid,
    input  result_set_t res_data,
    output logic        advance,
    output logic        out_valid,
    input  logic        out_ready,
    output result_set_t out_data
);

    localparam int DEPTH = `DFG_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    result_set_t mem [DEPTH];
    ptr_t        wr_ptr;
    ptr_t        rd_ptr;
    cnt_t        count;
    logic        wr_en;
    logic        pop;

    // advance comes from the registered count only, so no path from out_ready
    assign advance   = count < cnt_t'(DEPTH);
    // the datapath hands a result over on the same edge it shifts
    assign wr_en     = res_valid && advance;
    assign out_valid = count != '0;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clock)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= res_data;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a write while full would push the count past depth
    assert property (@(posedge clock) disable iff (rst)
        count == cnt_t'(DEPTH) |=> count <= cnt_t'(DEPTH))
        else $error("result queue written while full");

    // a pop while empty would wrap the count around
    assert property (@(posedge clock) disable iff (rst)
        count == '0 |=> count <= cnt_t'(1))
        else $error("result queue popped while empty");

endmodule

// File: list.f
+incdir+common
+incdir+tests
common/dfg_pkg.sv
datapath/arith_unit.sv
datapath/dfg_datapath.sv
design/result_queue.sv
design/dfg_top.sv
tests/tb_dfg_top.sv

// File: tests/tb_dfg_vectors.svh
// directed operand sets for the dataflow engine with their expected result sets
// columns: test name, operands {a, b, c, d, e}, expected results {r1, r2, r3, r4}

localparam int NUM_VECTORS = 8;

typedef struct {
    string        name;
    operand_set_t ops;
    result_set_t  exp;
} vector_t;

vector_t dir_vectors [NUM_VECTORS] = '{
    '{"zeros", {32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        {32'h0, 32'h0, 32'h0, 32'h0}},
    '{"ones", {32'h1, 32'h1, 32'h1, 32'h1, 32'h1},
        {32'h1e, 32'h7, 32'h12, 32'h5}},
    '{"small", {32'h1, 32'h2, 32'h3, 32'h4, 32'h5},
        {32'h1bd50, 32'haf, 32'h4650, 32'h5f}},
    '{"all_ones", {32'hffffffff, 32'hffffffff, 32'hffffffff, 32'hffffffff, 32'hffffffff},
        {32'hfffffffa, 32'hfffffffb, 32'hfffffffe, 32'hfffffffd}},
    // a + b wraps and so does t * u
    '{"add_overflow", {32'h80000000, 32'h80000001, 32'h1, 32'h1, 32'h1},
        {32'h6, 32'h4, 32'h4, 32'h80000003}},
    '{"mul_overflow", {32'h10000, 32'h0, 32'h10000, 32'h10000, 32'h1},
        {32'h0, 32'h10000, 32'h0, 32'h10000}},
    // both cross terms of c * d land in the upper half
    '{"mul_cross", {32'h0, 32'h0, 32'h10001, 32'h10001, 32'h0},
        {32'h0, 32'h20001, 32'h0, 32'h20001}},
    '{"negative_e", {32'h2, 32'h3, 32'h0, 32'h7, 32'hffffffff},
        {32'h276, 32'hffffffe9, 32'hfffffea2, 32'hfffffff7}}
};

// File: tests/tb_dfg_top.sv
// testbench for dfg_top with clock, reset, driver, reference model, monitor and checks
`timescale 1ns/1ps
`include "dfg_cfg.svh"

module tb_dfg_top
    import dfg_pkg::*;
;

    // edges from the accept edge, counted inclusively, to the edge that raises out_valid
    localparam int EXP_LATENCY   = 10;
    // nine packets in flight plus a full result queue
    localparam int PIPE_CAPACITY = 9 + `DFG_QUEUE_DEPTH;
    localparam int WAIT_LIMIT    = 200;
    localparam int DRAIN_LIMIT   = 2000;

    logic         clock;
    logic         rst;
    logic         in_valid;
    logic         in_ready;
    operand_set_t in_data;
    logic         out_valid;
    logic         out_ready;
    result_set_t  out_data;

    result_set_t exp_q [$];
    string       name_q [$];
    // 0 holds out_ready high, 1 holds it low, 2 randomizes it
    int          ready_mode = 0;
    logic        expect_ready = 1'b0;

    `include "tb_dfg_vectors.svh"

    dfg_top i_dut (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #50 clock = ~clock;
        end
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [159:0] expected,
                               input logic [159:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // graph evaluated straight from the dataflow rules, all words wrap mod 2^32
    function automatic result_set_t compute_expected(input operand_set_t o);
        word_t       p;
        word_t       q;
        word_t       s1;
        word_t       s2;
        word_t       t;
        word_t       u;
        word_t       v;
        word_t       w;
        result_set_t r;
        p  = o.a + o.b;
        q  = o.c * o.d;
        s1 = o.c + o.a;
        s2 = o.e * o.d;
        t  = p + q;
        u  = s1 * s2;
        v  = t + u;
        w  = t * u;
        r.r1 = v * w;
        r.r2 = v + u;
        r.r3 = t * w;
        r.r4 = t + u;
        return r;
    endfunction

    function automatic operand_set_t random_operands();
        operand_set_t o;
        o.a = $urandom();
        o.b = $urandom();
        o.c = $urandom();
        o.d = $urandom();
        o.e = $urandom();
        return o;
    endfunction

    // entered and left at the drive point, 5 ns after a rising edge
    task automatic send_packet(input operand_set_t ops, input result_set_t exp,
                               input string name);
        int   waited;
        logic taken;
        waited   = 0;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_data  = ops;
        while (!taken)
        begin
            taken = in_ready;
            if (taken)
            begin
                exp_q.push_back(exp);
                name_q.push_back(name);
            end
            @(posedge clock);
            #5;
            waited++;
            if (!taken && waited > WAIT_LIMIT)
            begin
                report_failure($sformatf("DUT stalled, in_ready stayed low for packet %s", name));
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n)
        begin
            @(posedge clock);
            #5;
        end
    endtask

    task automatic wait_drain(input string phase);
        int waited;
        waited = 0;
        while (exp_q.size() != 0)
        begin
            @(posedge clock);
            #5;
            waited++;
            if (waited > DRAIN_LIMIT)
            begin
                report_failure($sformatf("DUT stalled, %0d results never came out during %s",
                                         exp_q.size(), phase));
            end
        end
    endtask

    // out_ready changes at the drive point like every other input
    initial
    begin
        out_ready = 1'b1;
        forever
        begin
            @(posedge clock);
            #5;
            case (ready_mode)
                0:       out_ready = 1'b1;
                1:       out_ready = 1'b0;
                default: out_ready = ($urandom_range(0, 2) != 0);
            endcase
        end
    end

    // handshakes are sampled at the falling edge, where every signal is settled
    initial
    begin
        logic        held;
        result_set_t held_data;
        result_set_t exp_r;
        string       exp_name;
        held = 1'b0;
        held_data = '0;
        forever
        begin
            @(negedge clock);
            if (!rst)
            begin
                if (expect_ready)
                begin
                    check_value("streaming in_ready", 1, in_ready);
                end
                // a pending result must not move or vanish before its transfer
                if (held)
                begin
                    check_value("out_valid held", 1, out_valid);
                    check_value("out_data held", held_data, out_data);
                end
                if (out_valid && out_ready)
                begin
                    if (exp_q.size() == 0)
                    begin
                        report_failure("DUT returned a result with no packet outstanding");
                    end
                    exp_r    = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    check_value(exp_name, exp_r, out_data);
                end
                held      = out_valid && !out_ready;
                held_data = out_data;
            end
        end
    end

    initial
    begin
        operand_set_t ops;
        int           edges;
        int           filled;
        void'($urandom(32'h70f1));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;

        // reset state
        repeat (8)
        begin
            @(posedge clock);
            #5;
            check_value("reset out_valid", 0, out_valid);
            check_value("reset in_ready", 1, in_ready);
        end
        rst = 1'b0;
        @(posedge clock);
        #5;
        check_value("post reset out_valid", 0, out_valid);
        check_value("post reset in_ready", 1, in_ready);

        // directed table, one packet at a time
        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            check_value({dir_vectors[i].name, " model"},
                        dir_vectors[i].exp, compute_expected(dir_vectors[i].ops));
            send_packet(dir_vectors[i].ops, dir_vectors[i].exp, dir_vectors[i].name);
            idle_cycles(1);
            wait_drain(dir_vectors[i].name);
        end

        // latency into an idle DUT
        idle_cycles(2);
        ops = random_operands();
        check_value("latency in_ready", 1, in_ready);
        in_valid = 1'b1;
        in_data  = ops;
        exp_q.push_back(compute_expected(ops));
        name_q.push_back("latency");
        @(posedge clock);
        #5;
        in_valid = 1'b0;
        edges = 1;
        while (!out_valid)
        begin
            @(posedge clock);
            #5;
            edges++;
            if (edges > WAIT_LIMIT)
            begin
                report_failure("DUT stalled, out_valid never rose for the latency packet");
            end
        end
        check_value("latency", EXP_LATENCY, edges);
        wait_drain("latency");

        // back to back streaming with out_ready high
        expect_ready = 1'b1;
        for (int i = 0; i < 50; i++)
        begin
            ops = random_operands();
            send_packet(ops, compute_expected(ops), $sformatf("stream_%0d", i));
        end
        idle_cycles(1);
        wait_drain("streaming");
        expect_ready = 1'b0;

        // back-pressure, fill until in_ready falls
        ready_mode = 1;
        idle_cycles(1);
        filled = 0;
        while (in_ready)
        begin
            ops = random_operands();
            in_valid = 1'b1;
            in_data  = ops;
            exp_q.push_back(compute_expected(ops));
            name_q.push_back($sformatf("backpressure_%0d", filled));
            filled++;
            @(posedge clock);
            #5;
            if (filled > WAIT_LIMIT)
            begin
                report_failure("in_ready never fell while out_ready was held low");
            end
        end
        in_valid = 1'b0;
        check_value("backpressure capacity", PIPE_CAPACITY, filled);
        idle_cycles(5);
        check_value("backpressure in_ready", 0, in_ready);
        ready_mode = 0;
        wait_drain("backpressure");

        // random in_valid and out_ready
        ready_mode = 2;
        for (int i = 0; i < 200; i++)
        begin
            if ($urandom_range(0, 3) == 0)
            begin
                idle_cycles($urandom_range(1, 3));
            end
            ops = random_operands();
            send_packet(ops, compute_expected(ops), $sformatf("random_%0d", i));
        end
        idle_cycles(1);
        wait_drain("random traffic");
        ready_mode = 0;
        // any extra output shows up here as an unexpected result
        idle_cycles(20);

        $display("Test completed successfully");
        $finish;
    end

endmodule
